// ==== design/exu_pkg.sv ====
package exu_pkg;

  // datapath and address width
  localparam int XLEN = 32;

  typedef logic [11:0] csr_addr_t;

  // machine csr addresses
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  // environment call from m-mode
  localparam logic [XLEN-1:0] CAUSE_ECALL_M = XLEN'(11);

  // operation class, from decode
  typedef enum logic [3:0] {
    op_alu    = 4'd0,
    op_branch = 4'd1,
    op_jal    = 4'd2,
    op_jalr   = 4'd3,
    op_load   = 4'd4,
    op_store  = 4'd5,
    op_csrrw  = 4'd6,
    op_csrrs  = 4'd7,
    op_csrrc  = 4'd8,
    op_ecall  = 4'd9,
    op_mret   = 4'd10,
    op_ebreak = 4'd11
  } exu_op_e;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_xor  = 4'd2,
    alu_or   = 4'd3,
    alu_and  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9
  } alu_op_e;

endpackage

// ==== design/exu_alu.sv ====
`timescale 1ns/1ns

module exu_alu import exu_pkg::*; (
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  input  alu_op_e         alu_op_i,
  output logic [XLEN-1:0] res_o
);

  logic [4:0] shamt;

  assign shamt = src2_i[4:0];

  always_comb begin
    case (alu_op_i)
      alu_add: begin
        res_o = src1_i + src2_i;
      end
      alu_sub: begin
        res_o = src1_i - src2_i;
      end
      alu_xor: begin
        res_o = src1_i ^ src2_i;
      end
      alu_or: begin
        res_o = src1_i | src2_i;
      end
      alu_and: begin
        res_o = src1_i & src2_i;
      end
      alu_sll: begin
        res_o = src1_i << shamt;
      end
      alu_srl: begin
        res_o = src1_i >> shamt;
      end
      alu_sra: begin
        res_o = $unsigned($signed(src1_i) >>> shamt);
      end
      alu_slt: begin
        res_o = {{(XLEN-1){1'b0}}, $signed(src1_i) < $signed(src2_i)};
      end
      alu_sltu: begin
        res_o = {{(XLEN-1){1'b0}}, src1_i < src2_i};
      end
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule

// ==== design/exu_csr.sv ====
`timescale 1ns/1ns

module exu_csr import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            wen_i,
  input  csr_addr_t       addr_i,
  input  logic [XLEN-1:0] wdata_i,
  input  logic            ecall_i,
  input  logic            mret_i,
  input  logic [XLEN-1:0] epc_i,
  output logic [XLEN-1:0] rdata_o,
  output logic [XLEN-1:0] mtvec_o,
  output logic [XLEN-1:0] mepc_o
);

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (ecall_i) begin
      mepc_q   <= epc_i;
      mcause_q <= CAUSE_ECALL_M;
    end else if (mret_i) begin
      // mpie -> mie, mpie set
      mstatus_q[7] <= 1'b1;
      mstatus_q[3] <= mstatus_q[7];
    end else if (wen_i) begin
      case (addr_i)
        CSR_MSTATUS: begin
          mstatus_q <= wdata_i;
        end
        CSR_MTVEC: begin
          mtvec_q <= wdata_i;
        end
        CSR_MEPC: begin
          mepc_q <= wdata_i;
        end
        CSR_MCAUSE: begin
          mcause_q <= wdata_i;
        end
        default: begin
        end
      endcase
    end
  end

  // unknown address reads as zero
  always_comb begin
    case (addr_i)
      CSR_MSTATUS: rdata_o = mstatus_q;
      CSR_MTVEC:   rdata_o = mtvec_q;
      CSR_MEPC:    rdata_o = mepc_q;
      CSR_MCAUSE:  rdata_o = mcause_q;
      default:     rdata_o = '0;
    endcase
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

endmodule

// ==== design/exu_lsu.sv ====
`timescale 1ns/1ns

module exu_lsu import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            req_i,
  input  logic            write_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic            done_o,
  output logic [XLEN-1:0] rdata_o,
  output logic            psel_o,
  output logic            penable_o,
  output logic            pwrite_o,
  output logic [XLEN-1:0] paddr_o,
  output logic [XLEN-1:0] pwdata_o,
  input  logic [XLEN-1:0] prdata_i,
  input  logic            pready_i
);

  typedef enum logic [1:0] {
    lsu_idle,
    lsu_setup,
    lsu_access
  } lsu_state_e;

  lsu_state_e state_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= lsu_idle;
    end else begin
      case (state_q)
        lsu_idle: begin
          if (req_i) begin
            state_q <= lsu_setup;
          end
        end
        lsu_setup: begin
          state_q <= lsu_access;
        end
        lsu_access: begin
          if (pready_i) begin
            state_q <= lsu_idle;
          end
        end
        default: begin
          state_q <= lsu_idle;
        end
      endcase
    end
  end

  // request held stable for the whole transfer
  always_ff @(posedge clk) begin
    if (state_q == lsu_idle && req_i) begin
      pwrite_o <= write_i;
      paddr_o  <= addr_i;
      pwdata_o <= wdata_i;
    end
    if (done_o) begin
      rdata_o <= prdata_i;
    end
  end

  assign psel_o    = (state_q != lsu_idle);
  assign penable_o = (state_q == lsu_access);
  assign done_o    = (state_q == lsu_access) && pready_i;

endmodule

// ==== design/exu_stage.sv ====
`timescale 1ns/1ns

module exu_stage import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  // input handshake
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  exu_op_e         op_i,
  input  alu_op_e         alu_op_i,
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [4:0]      rd_i,
  input  csr_addr_t       csr_addr_i,
  // output handshake
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output logic [4:0]      rd_o,
  output logic            rd_wen_o,
  output logic [XLEN-1:0] rd_wdata_o,
  output logic            redirect_o,
  output logic [XLEN-1:0] npc_o,
  output logic            ebreak_o,
  // lsu
  output logic            mem_req_o,
  output logic            mem_write_o,
  output logic [XLEN-1:0] mem_addr_o,
  output logic [XLEN-1:0] mem_wdata_o,
  input  logic            mem_done_i,
  input  logic [XLEN-1:0] mem_rdata_i,
  // alu
  output logic [XLEN-1:0] alu_src1_o,
  output logic [XLEN-1:0] alu_src2_o,
  output alu_op_e         alu_op_o,
  input  logic [XLEN-1:0] alu_res_i,
  // csr file
  output csr_addr_t       csr_addr_o,
  output logic            csr_wen_o,
  output logic [XLEN-1:0] csr_wdata_o,
  output logic [XLEN-1:0] csr_epc_o,
  output logic            trap_ecall_o,
  output logic            trap_mret_o,
  input  logic [XLEN-1:0] csr_rdata_i,
  input  logic [XLEN-1:0] mtvec_i,
  input  logic [XLEN-1:0] mepc_i
);

  logic busy_q;
  logic res_valid_q;
  logic in_fire;
  logic out_fire;
  logic in_mem;
  logic is_csr;

  exu_op_e         op_q;
  alu_op_e         alu_op_q;
  logic [XLEN-1:0] src1_q;
  logic [XLEN-1:0] src2_q;
  logic [XLEN-1:0] imm_q;
  logic [XLEN-1:0] pc_q;
  logic [4:0]      rd_q;
  csr_addr_t       csr_addr_q;

  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] br_target;
  logic [XLEN-1:0] jalr_target;

  assign in_fire  = in_valid_i && in_ready_o;
  assign out_fire = res_valid_q && out_ready_i;
  assign in_mem   = (op_i == op_load) || (op_i == op_store);
  assign is_csr   = (op_q == op_csrrw) || (op_q == op_csrrs) || (op_q == op_csrrc);

  // a result never shows while memory is pending
  assign in_ready_o = !busy_q || out_fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q      <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      if (out_fire) begin
        busy_q      <= 1'b0;
        res_valid_q <= 1'b0;
      end
      if (mem_done_i) begin
        res_valid_q <= 1'b1;
      end
      if (in_fire) begin
        busy_q      <= 1'b1;
        res_valid_q <= !in_mem;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      op_q       <= op_i;
      alu_op_q   <= alu_op_i;
      src1_q     <= src1_i;
      src2_q     <= src2_i;
      imm_q      <= imm_i;
      pc_q       <= pc_i;
      rd_q       <= rd_i;
      csr_addr_q <= csr_addr_i;
    end
  end

  // lsu starts its setup phase right after the transfer edge
  assign mem_req_o   = in_fire && in_mem;
  assign mem_write_o = (op_i == op_store);
  assign mem_addr_o  = src1_i + imm_i;
  assign mem_wdata_o = src2_i;

  assign alu_src1_o = src1_q;
  assign alu_src2_o = src2_q;
  assign alu_op_o   = alu_op_q;

  assign pc_plus4    = pc_q + XLEN'(4);
  assign br_target   = pc_q + imm_q;
  assign jalr_target = (src1_q + imm_q) & ~XLEN'(1);

  always_comb begin
    rd_wen_o    = 1'b0;
    rd_wdata_o  = alu_res_i;
    redirect_o  = 1'b0;
    npc_o       = pc_plus4;
    ebreak_o    = 1'b0;
    csr_wdata_o = src1_q;
    case (op_q)
      op_alu: begin
        rd_wen_o = 1'b1;
      end
      op_branch: begin
        // beq uses sub, the others test for nonzero
        if (alu_op_q == alu_sub) begin
          redirect_o = (alu_res_i == '0);
        end else begin
          redirect_o = (alu_res_i != '0);
        end
        if (redirect_o) begin
          npc_o = br_target;
        end
      end
      op_jal: begin
        rd_wen_o   = 1'b1;
        rd_wdata_o = pc_plus4;
        redirect_o = 1'b1;
        npc_o      = br_target;
      end
      op_jalr: begin
        rd_wen_o   = 1'b1;
        rd_wdata_o = pc_plus4;
        redirect_o = 1'b1;
        npc_o      = jalr_target;
      end
      op_load: begin
        rd_wen_o   = 1'b1;
        rd_wdata_o = mem_rdata_i;
      end
      op_csrrw: begin
        rd_wen_o   = 1'b1;
        rd_wdata_o = csr_rdata_i;
      end
      op_csrrs: begin
        rd_wen_o    = 1'b1;
        rd_wdata_o  = csr_rdata_i;
        csr_wdata_o = csr_rdata_i | src1_q;
      end
      op_csrrc: begin
        rd_wen_o    = 1'b1;
        rd_wdata_o  = csr_rdata_i;
        csr_wdata_o = csr_rdata_i & ~src1_q;
      end
      op_ecall: begin
        redirect_o = 1'b1;
        npc_o      = mtvec_i;
      end
      op_mret: begin
        redirect_o = 1'b1;
        npc_o      = mepc_i;
      end
      op_ebreak: begin
        ebreak_o = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // csr side effects happen once, on the output transfer
  assign csr_addr_o   = csr_addr_q;
  assign csr_wen_o    = out_fire && is_csr;
  assign csr_epc_o    = pc_q;
  assign trap_ecall_o = out_fire && (op_q == op_ecall);
  assign trap_mret_o  = out_fire && (op_q == op_mret);

  assign out_valid_o = res_valid_q;
  assign rd_o        = rd_q;

endmodule

// ==== design/exu_top.sv ====
`timescale 1ns/1ns

module exu_top import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  exu_op_e         op_i,
  input  alu_op_e         alu_op_i,
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [4:0]      rd_i,
  input  csr_addr_t       csr_addr_i,
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output logic [4:0]      rd_o,
  output logic            rd_wen_o,
  output logic [XLEN-1:0] rd_wdata_o,
  output logic            redirect_o,
  output logic [XLEN-1:0] npc_o,
  output logic            ebreak_o,
  // apb to data memory
  output logic            psel_o,
  output logic            penable_o,
  output logic            pwrite_o,
  output logic [XLEN-1:0] paddr_o,
  output logic [XLEN-1:0] pwdata_o,
  input  logic [XLEN-1:0] prdata_i,
  input  logic            pready_i
);

  logic            mem_req;
  logic            mem_write;
  logic [XLEN-1:0] mem_addr;
  logic [XLEN-1:0] mem_wdata;
  logic            mem_done;
  logic [XLEN-1:0] mem_rdata;

  logic [XLEN-1:0] alu_src1;
  logic [XLEN-1:0] alu_src2;
  alu_op_e         alu_op;
  logic [XLEN-1:0] alu_res;

  csr_addr_t       csr_addr;
  logic            csr_wen;
  logic [XLEN-1:0] csr_wdata;
  logic [XLEN-1:0] csr_epc;
  logic            trap_ecall;
  logic            trap_mret;
  logic [XLEN-1:0] csr_rdata;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;

  exu_stage i_stage (
    .clk          (clk),
    .rst          (rst),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .op_i         (op_i),
    .alu_op_i     (alu_op_i),
    .src1_i       (src1_i),
    .src2_i       (src2_i),
    .imm_i        (imm_i),
    .pc_i         (pc_i),
    .rd_i         (rd_i),
    .csr_addr_i   (csr_addr_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .rd_o         (rd_o),
    .rd_wen_o     (rd_wen_o),
    .rd_wdata_o   (rd_wdata_o),
    .redirect_o   (redirect_o),
    .npc_o        (npc_o),
    .ebreak_o     (ebreak_o),
    .mem_req_o    (mem_req),
    .mem_write_o  (mem_write),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_done_i   (mem_done),
    .mem_rdata_i  (mem_rdata),
    .alu_src1_o   (alu_src1),
    .alu_src2_o   (alu_src2),
    .alu_op_o     (alu_op),
    .alu_res_i    (alu_res),
    .csr_addr_o   (csr_addr),
    .csr_wen_o    (csr_wen),
    .csr_wdata_o  (csr_wdata),
    .csr_epc_o    (csr_epc),
    .trap_ecall_o (trap_ecall),
    .trap_mret_o  (trap_mret),
    .csr_rdata_i  (csr_rdata),
    .mtvec_i      (mtvec),
    .mepc_i       (mepc)
  );

  exu_alu i_alu (
    .src1_i   (alu_src1),
    .src2_i   (alu_src2),
    .alu_op_i (alu_op),
    .res_o    (alu_res)
  );

  exu_csr i_csr (
    .clk     (clk),
    .rst     (rst),
    .wen_i   (csr_wen),
    .addr_i  (csr_addr),
    .wdata_i (csr_wdata),
    .ecall_i (trap_ecall),
    .mret_i  (trap_mret),
    .epc_i   (csr_epc),
    .rdata_o (csr_rdata),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

  exu_lsu i_lsu (
    .clk       (clk),
    .rst       (rst),
    .req_i     (mem_req),
    .write_i   (mem_write),
    .addr_i    (mem_addr),
    .wdata_i   (mem_wdata),
    .done_o    (mem_done),
    .rdata_o   (mem_rdata),
    .psel_o    (psel_o),
    .penable_o (penable_o),
    .pwrite_o  (pwrite_o),
    .paddr_o   (paddr_o),
    .pwdata_o  (pwdata_o),
    .prdata_i  (prdata_i),
    .pready_i  (pready_i)
  );

endmodule

// ==== bench/apb_mem_model.sv ====
`timescale 1ns/1ns

module apb_mem_model import exu_pkg::*; (
  input  logic            clk,
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  logic [XLEN-1:0] paddr_i,
  input  logic [XLEN-1:0] pwdata_i,
  output logic [XLEN-1:0] prdata_o,
  output logic            pready_o
);

  logic [XLEN-1:0] mem [0:255];
  int unsigned     wait_cnt = 0;
  integer          mem_seed = 35826;

  initial begin : clear_mem
    int i;
    for (i = 0; i < 256; i++) begin
      mem[i] <= '0;
    end
  end

  // wait states drawn in the setup phase
  always @(posedge clk) begin
    if (psel_i && !penable_i) begin
      wait_cnt <= $unsigned($random(mem_seed)) % 4;
    end else if (psel_i && penable_i) begin
      if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1;
      end else if (pwrite_i) begin
        mem[paddr_i[9:2]] <= pwdata_i;
      end
    end
  end

  assign pready_o = psel_i && penable_i && (wait_cnt == 0);
  assign prdata_o = mem[paddr_i[9:2]];

endmodule

// ==== bench/exu_sva.sv ====
`timescale 1ns/1ns

module exu_sva import exu_pkg::*; (
  input logic            clk,
  input logic            rst,
  input logic            psel_i,
  input logic            penable_i,
  input logic            pwrite_i,
  input logic [XLEN-1:0] paddr_i,
  input logic [XLEN-1:0] pwdata_i,
  input logic            pready_i,
  input logic            out_valid_i,
  input logic            out_ready_i,
  input logic [4:0]      rd_i,
  input logic            rd_wen_i,
  input logic [XLEN-1:0] rd_wdata_i,
  input logic            redirect_i,
  input logic [XLEN-1:0] npc_i,
  input logic            ebreak_i
);

  int fail_cnt = 0;

  apb_hold: assert property (@(posedge clk) disable iff (rst)
    psel_i && !pready_i |=> $stable(paddr_i) && $stable(pwdata_i) && $stable(pwrite_i))
    else begin
      fail_cnt++;
      $error("apb address, data or direction changed before pready");
    end

  // one setup cycle, then access
  apb_phase: assert property (@(posedge clk) disable iff (rst)
    $rose(psel_i) |-> !penable_i ##1 (psel_i && penable_i))
    else begin
      fail_cnt++;
      $error("penable did not follow psel after one setup cycle");
    end

  out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(rd_i) && $stable(rd_wen_i)
      && $stable(rd_wdata_i) && $stable(redirect_i) && $stable(npc_i) && $stable(ebreak_i))
    else begin
      fail_cnt++;
      $error("result changed while out_ready was low");
    end

endmodule

bind exu_top exu_sva i_exu_sva (
  .clk         (clk),
  .rst         (rst),
  .psel_i      (psel_o),
  .penable_i   (penable_o),
  .pwrite_i    (pwrite_o),
  .paddr_i     (paddr_o),
  .pwdata_i    (pwdata_o),
  .pready_i    (pready_i),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .rd_i        (rd_o),
  .rd_wen_i    (rd_wen_o),
  .rd_wdata_i  (rd_wdata_o),
  .redirect_i  (redirect_o),
  .npc_i       (npc_o),
  .ebreak_i    (ebreak_o)
);

// ==== bench/tb_exu_top.sv ====
`timescale 1ns/1ns

module tb_exu_top import exu_pkg::*; ();

  localparam int TIMEOUT = 200;

  typedef struct packed {
    logic [4:0]      rd;
    logic            wen;
    logic [XLEN-1:0] wdata;
    logic            redirect;
    logic [XLEN-1:0] npc;
    logic            ebreak;
    logic            lat_chk;
    int              issue_cyc;
  } exp_t;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic in_valid_i = 1'b0;
  logic in_ready_o;
  exu_op_e op_i = op_alu;
  alu_op_e alu_op_i = alu_add;
  logic [XLEN-1:0] src1_i = '0;
  logic [XLEN-1:0] src2_i = '0;
  logic [XLEN-1:0] imm_i = '0;
  logic [XLEN-1:0] pc_i = '0;
  logic [4:0] rd_i = '0;
  csr_addr_t csr_addr_i = '0;
  logic out_valid_o;
  logic out_ready_i = 1'b1;
  logic [4:0] rd_o;
  logic rd_wen_o;
  logic [XLEN-1:0] rd_wdata_o;
  logic redirect_o;
  logic [XLEN-1:0] npc_o;
  logic ebreak_o;
  logic psel_o;
  logic penable_o;
  logic pwrite_o;
  logic [XLEN-1:0] paddr_o;
  logic [XLEN-1:0] pwdata_o;
  logic [XLEN-1:0] prdata_i;
  logic pready_i;

  integer seed = 35826;
  integer ready_seed = 35826;
  int cycle_cnt = 0;
  int err_value = 0;
  int err_other = 0;
  int n_in = 0;
  int n_out = 0;
  int stall_left = 0;
  logic stall_en = 1'b0;
  logic [XLEN-1:0] cur_pc = 32'h0000_1000;
  exp_t exp_q[$];

  // reference architectural state
  logic [XLEN-1:0] ref_mstatus = '0;
  logic [XLEN-1:0] ref_mtvec = '0;
  logic [XLEN-1:0] ref_mepc = '0;
  logic [XLEN-1:0] ref_mcause = '0;
  logic [XLEN-1:0] ref_mem [0:255];
  alu_op_e br_ops [4] = '{alu_sub, alu_xor, alu_slt, alu_sltu};

  exu_top i_exu_top (.*);

  apb_mem_model i_mem (
    .clk       (clk),
    .psel_i    (psel_o),
    .penable_i (penable_o),
    .pwrite_i  (pwrite_o),
    .paddr_i   (paddr_o),
    .pwdata_i  (pwdata_o),
    .prdata_o  (prdata_i),
    .pready_o  (pready_i)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // random back-pressure in stretches
  always @(posedge clk) begin
    #10;
    if (!stall_en) begin
      out_ready_i = 1'b1;
    end else if (stall_left > 0) begin
      out_ready_i = 1'b0;
      stall_left--;
    end else if (($random(ready_seed) & 3) == 0) begin
      out_ready_i = 1'b0;
      stall_left = $unsigned($random(ready_seed)) % 6;
    end else begin
      out_ready_i = 1'b1;
    end
  end

  function automatic logic [XLEN-1:0] next_rand();
    return $random(seed);
  endfunction

  function automatic logic [XLEN-1:0] alu_ref(alu_op_e aop, logic [XLEN-1:0] a,
                                              logic [XLEN-1:0] b);
    logic [4:0]      sh;
    logic [XLEN-1:0] fill;
    sh = b[4:0];
    fill = a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;
    case (aop)
      alu_add:  return a + b;
      alu_sub:  return a + ~b + 1;
      alu_xor:  return a ^ b;
      alu_or:   return a | b;
      alu_and:  return a & b;
      alu_sll:  return a << sh;
      alu_srl:  return a >> sh;
      alu_sra:  return (a >> sh) | fill;
      alu_slt:  return (a[XLEN-1] != b[XLEN-1]) ? XLEN'(a[XLEN-1]) : XLEN'(a < b);
      alu_sltu: return XLEN'(a < b);
      default:  return '0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] csr_read(csr_addr_t ca);
    case (ca)
      CSR_MSTATUS: return ref_mstatus;
      CSR_MTVEC:   return ref_mtvec;
      CSR_MEPC:    return ref_mepc;
      CSR_MCAUSE:  return ref_mcause;
      default:     return '0;
    endcase
  endfunction

  function automatic void csr_write(csr_addr_t ca, logic [XLEN-1:0] v);
    case (ca)
      CSR_MSTATUS: ref_mstatus = v;
      CSR_MTVEC:   ref_mtvec = v;
      CSR_MEPC:    ref_mepc = v;
      CSR_MCAUSE:  ref_mcause = v;
      default: begin
      end
    endcase
  endfunction

  // expected result in program order and the matching reference state update
  function automatic exp_t exu_ref(exu_op_e op, alu_op_e aop, logic [XLEN-1:0] s1,
                                   logic [XLEN-1:0] s2, logic [XLEN-1:0] imm,
                                   logic [XLEN-1:0] pc, logic [4:0] rd, csr_addr_t ca);
    exp_t            e;
    logic [XLEN-1:0] res;
    logic [XLEN-1:0] old;
    logic [XLEN-1:0] addr;
    e = '0;
    e.rd = rd;
    res = alu_ref(aop, s1, s2);
    old = csr_read(ca);
    addr = s1 + imm;
    case (op)
      op_alu: begin
        e.wen = 1'b1;
        e.wdata = res;
      end
      op_branch: begin
        e.redirect = (aop == alu_sub) ? (res == 0) : (res != 0);
        e.npc = pc + imm;
      end
      op_jal, op_jalr: begin
        e.wen = 1'b1;
        e.wdata = pc + 4;
        e.redirect = 1'b1;
        e.npc = (op == op_jal) ? pc + imm : (s1 + imm) & 32'hffff_fffe;
      end
      op_load: begin
        e.wen = 1'b1;
        e.wdata = ref_mem[addr[9:2]];
      end
      op_store: ref_mem[addr[9:2]] = s2;
      op_csrrw, op_csrrs, op_csrrc: begin
        e.wen = 1'b1;
        e.wdata = old;
        if (op == op_csrrw) csr_write(ca, s1);
        else if (op == op_csrrs) csr_write(ca, old | s1);
        else csr_write(ca, old & ~s1);
      end
      op_ecall: begin
        e.redirect = 1'b1;
        e.npc = ref_mtvec;
        ref_mepc = pc;
        ref_mcause = 32'd11;
      end
      op_mret: begin
        e.redirect = 1'b1;
        e.npc = ref_mepc;
        ref_mstatus[3] = ref_mstatus[7];
        ref_mstatus[7] = 1'b1;
      end
      op_ebreak: e.ebreak = 1'b1;
      default: begin
      end
    endcase
    return e;
  endfunction

  task automatic check_word(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
    if (got !== exp) begin
      err_value++;
      $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      err_value++;
      $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_rd(string name, logic [4:0] got, logic [4:0] exp);
    if (got !== exp) begin
      err_value++;
      $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic abort_on_timeout(string what);
    $display("timeout: no %s within %0d cycles", what, TIMEOUT);
    $display("Test failed");
    $finish;
  endtask

  // starts and returns 10 ns after a rising edge
  task automatic send_op(exu_op_e op, alu_op_e aop, logic [XLEN-1:0] s1, logic [XLEN-1:0] s2,
                         logic [XLEN-1:0] imm, logic [4:0] rd, csr_addr_t ca, logic lat_chk);
    exp_t e;
    int   waited;
    op_i = op;
    alu_op_i = aop;
    src1_i = s1;
    src2_i = s2;
    imm_i = imm;
    pc_i = cur_pc;
    rd_i = rd;
    csr_addr_i = ca;
    in_valid_i = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!in_ready_o) begin
      waited++;
      if (waited > TIMEOUT) abort_on_timeout("input handshake");
      @(negedge clk);
    end
    e = exu_ref(op, aop, s1, s2, imm, cur_pc, rd, ca);
    e.lat_chk = lat_chk;
    e.issue_cyc = cycle_cnt;
    exp_q.push_back(e);
    n_in++;
    @(posedge clk);
    #10;
    in_valid_i = 1'b0;
    cur_pc = cur_pc + 4;
  endtask

  task automatic send_alu(logic lat_chk);
    send_op(op_alu, alu_op_e'(4'(next_rand() % 10)), next_rand(), next_rand(), '0,
            5'(next_rand()), '0, lat_chk);
  endtask

  task automatic send_branch(int k);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    a = next_rand();
    if (next_rand() % 2 == 0) b = a;
    else b = next_rand();
    send_op(op_branch, br_ops[k % 4], a, b, next_rand() & 32'h0000_0ffc, 5'(next_rand()),
            '0, 1'b0);
  endtask

  // small address window so loads hit earlier stores
  task automatic send_mem_op(logic is_store);
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] off;
    base = (next_rand() % 32) << 2;
    off = (next_rand() % 4) << 2;
    send_op(is_store ? op_store : op_load, alu_add, base, next_rand(), off, 5'(next_rand()),
            '0, 1'b0);
  endtask

  initial begin : compare_results
    exp_t e;
    forever begin
      @(negedge clk);
      if (!rst && out_valid_o && out_ready_i) begin
        n_out++;
        if (exp_q.size() == 0) begin
          err_other++;
          $display("result at %0t with no operation outstanding", $time);
        end else begin
          e = exp_q.pop_front();
          check_rd("rd_o", rd_o, e.rd);
          check_bit("rd_wen_o", rd_wen_o, e.wen);
          if (e.wen) check_word("rd_wdata_o", rd_wdata_o, e.wdata);
          check_bit("redirect_o", redirect_o, e.redirect);
          if (e.redirect) check_word("npc_o", npc_o, e.npc);
          check_bit("ebreak_o", ebreak_o, e.ebreak);
          if (e.lat_chk && cycle_cnt != e.issue_cyc + 1) begin
            err_other++;
            $display("result at %0t came %0d cycles after its input, not 1", $time,
                     cycle_cnt - e.issue_cyc);
          end
        end
      end
    end
  end

  initial begin : main_flow
    int i;
    int waited;
    int err_assert;
    for (i = 0; i < 256; i++) begin
      ref_mem[i] = '0;
    end
    repeat (8) @(posedge clk);
    #10;
    rst = 1'b0;

    for (i = 0; i < 200; i++) begin
      send_alu(1'b1);
    end
    for (i = 0; i < 40; i++) begin
      send_branch(i);
    end
    send_op(op_jal, alu_add, next_rand(), '0, next_rand() & 32'h0000_0ffc, 5'd1, '0, 1'b0);
    send_op(op_jalr, alu_add, next_rand(), '0, next_rand(), 5'd1, '0, 1'b0);
    for (i = 0; i < 60; i++) begin
      send_mem_op(next_rand() % 2 == 0);
    end

    for (i = 0; i < 6; i++) begin
      send_op(op_csrrw, alu_add, next_rand(), '0, '0, 5'd3, i % 2 ? CSR_MEPC : CSR_MTVEC, 1'b0);
      send_op(op_csrrs, alu_add, next_rand(), '0, '0, 5'd4, i % 2 ? CSR_MEPC : CSR_MTVEC, 1'b0);
      send_op(op_csrrc, alu_add, next_rand(), '0, '0, 5'd5, i % 2 ? CSR_MEPC : CSR_MTVEC, 1'b0);
    end
    send_op(op_csrrw, alu_add, next_rand(), '0, '0, 5'd6, 12'h7c0, 1'b0);
    send_op(op_csrrs, alu_add, '0, '0, '0, 5'd6, 12'h7c0, 1'b0);

    // trap entry and return
    send_op(op_csrrw, alu_add, 32'h0000_0200, '0, '0, 5'd7, CSR_MTVEC, 1'b0);
    send_op(op_ecall, alu_add, '0, '0, '0, 5'd0, '0, 1'b0);
    send_op(op_mret, alu_add, '0, '0, '0, 5'd0, '0, 1'b0);
    send_op(op_csrrs, alu_add, '0, '0, '0, 5'd8, CSR_MCAUSE, 1'b0);
    send_op(op_csrrs, alu_add, '0, '0, '0, 5'd9, CSR_MSTATUS, 1'b0);
    send_op(op_ebreak, alu_add, '0, '0, '0, 5'd0, '0, 1'b0);

    stall_en = 1'b1;
    for (i = 0; i < 80; i++) begin
      case (next_rand() % 4)
        0: send_alu(1'b0);
        1: send_branch(i);
        2: send_mem_op(1'b1);
        default: send_mem_op(1'b0);
      endcase
    end
    stall_en = 1'b0;

    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) abort_on_timeout("final results");
      @(negedge clk);
    end
    // idle cycle in which no repeated result may appear
    repeat (2) @(posedge clk);
    if (n_out != n_in) begin
      err_other++;
      $display("got %0d results for %0d accepted operations", n_out, n_in);
    end
    err_assert = i_exu_top.i_exu_sva.fail_cnt;
    $display("errors: %0d value mismatches, %0d assertion, %0d other; %0d results for %0d inputs",
             err_value, err_assert, err_other, n_out, n_in);
    if (err_value == 0 && err_other == 0 && err_assert == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
design/exu_pkg.sv
design/exu_alu.sv
design/exu_csr.sv
design/exu_lsu.sv
design/exu_stage.sv
design/exu_top.sv
bench/apb_mem_model.sv
bench/exu_sva.sv
bench/tb_exu_top.sv
